/* include/cpu_backend_params.svh */
`ifndef CPU_BACKEND_PARAMS_SVH
`define CPU_BACKEND_PARAMS_SVH

// operand and memory word width
`define CPU_DATA_WIDTH     64

// sixteen registers
`define CPU_REG_ADDR_WIDTH 4

// data memory words, indexed by byte address / 8
`define CPU_DMEM_DEPTH     64

`endif

/* hw/cpu_backend_pkg.sv */
package cpu_backend_pkg;

   // alu opcodes, shifts take the low six bits of operand b
   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6,
      ALU_SLT = 3'd7  // signed, gives 1 or 0
   } alu_op_e;

endpackage

/* hw/exmem_if.sv */
`timescale 1ns/1ps

`include "cpu_backend_params.svh"

interface exmem_if;

   logic                           mem_read;
   logic                           mem_write;
   logic                           reg_write;
   logic [`CPU_REG_ADDR_WIDTH-1:0] write_reg;
   logic [`CPU_DATA_WIDTH-1:0]     store_data;
   logic [`CPU_DATA_WIDTH-1:0]     alu_result;
   logic                           alu_zero;
   logic [`CPU_DATA_WIDTH-1:0]     branch_address;
   logic                           branch_en;

   modport producer
   (
      output mem_read, mem_write, reg_write, write_reg, store_data,
      output alu_result, alu_zero, branch_address, branch_en
   );

   modport consumer
   (
      input  mem_read, mem_write, reg_write, write_reg, store_data,
      input  alu_result, alu_zero, branch_address, branch_en
   );

endinterface

/* hw/register_file.sv */
`timescale 1ns/1ps

`include "cpu_backend_params.svh"

module register_file
(
   input  logic                           clock,
   input  logic                           reset,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rs1_addr_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rs2_addr_i,
   output logic [`CPU_DATA_WIDTH-1:0]     rs1_data_o,
   output logic [`CPU_DATA_WIDTH-1:0]     rs2_data_o,
   input  logic                           wr_en_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] wr_addr_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     wr_data_i
);

   localparam int NUM_REGS = 1 << `CPU_REG_ADDR_WIDTH;

   logic [`CPU_DATA_WIDTH-1:0] regs [NUM_REGS];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr_en_i)
      begin
         regs[wr_addr_i] <= wr_data_i;  // r0 is writable too
      end
   end

   // no bypass here, mem/wb forwarding handles the write cycle
   assign rs1_data_o = regs[rs1_addr_i];
   assign rs2_data_o = regs[rs2_addr_i];

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

`include "cpu_backend_params.svh"

module execute_stage
(
   input  logic                           issue_valid_i,
   input  cpu_backend_pkg::alu_op_e       alu_op_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rs1_addr_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rs2_addr_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rd_addr_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     imm_i,
   input  logic                           use_imm_i,
   input  logic                           mem_read_i,
   input  logic                           mem_write_i,
   input  logic                           reg_write_i,
   input  logic                           branch_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     pc_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     rs1_data_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     rs2_data_i,
   exmem_if.consumer                      fwd_mem_i,
   input  logic                           wb_valid_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] wb_addr_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     wb_data_i,
   exmem_if.producer                      ex_o
);

   logic                       fwd_ok;      // ex/mem item has its value ready
   logic [`CPU_DATA_WIDTH-1:0] op1;
   logic [`CPU_DATA_WIDTH-1:0] rs2_val;
   logic [`CPU_DATA_WIDTH-1:0] op2;
   logic [`CPU_DATA_WIDTH-1:0] result;
   logic                       zero;

   // a load in ex/mem has no data yet, issuer leaves a gap
   assign fwd_ok = fwd_mem_i.reg_write && !fwd_mem_i.mem_read;

   always_comb
   begin
      if (fwd_ok && fwd_mem_i.write_reg == rs1_addr_i)
         op1 = fwd_mem_i.alu_result;
      else if (wb_valid_i && wb_addr_i == rs1_addr_i)
         op1 = wb_data_i;
      else
         op1 = rs1_data_i;

      if (fwd_ok && fwd_mem_i.write_reg == rs2_addr_i)
         rs2_val = fwd_mem_i.alu_result;
      else if (wb_valid_i && wb_addr_i == rs2_addr_i)
         rs2_val = wb_data_i;
      else
         rs2_val = rs2_data_i;
   end

   assign op2 = use_imm_i ? imm_i : rs2_val;

   always_comb
   begin
      result = '0;
      case (alu_op_i)
         cpu_backend_pkg::ALU_ADD: result = op1 + op2;
         cpu_backend_pkg::ALU_SUB: result = op1 - op2;
         cpu_backend_pkg::ALU_AND: result = op1 & op2;
         cpu_backend_pkg::ALU_OR:  result = op1 | op2;
         cpu_backend_pkg::ALU_XOR: result = op1 ^ op2;
         cpu_backend_pkg::ALU_SLL: result = op1 << op2[5:0];
         cpu_backend_pkg::ALU_SRL: result = op1 >> op2[5:0];
         cpu_backend_pkg::ALU_SLT:
            result = {{(`CPU_DATA_WIDTH-1){1'b0}}, $signed(op1) < $signed(op2)};
         default:                  result = '0;
      endcase
   end

   assign zero = (result == '0);

   assign ex_o.mem_read       = issue_valid_i & mem_read_i;
   assign ex_o.mem_write      = issue_valid_i & mem_write_i;
   assign ex_o.reg_write      = issue_valid_i & reg_write_i;
   assign ex_o.alu_zero       = issue_valid_i & zero;
   assign ex_o.branch_en      = issue_valid_i & branch_i & zero;  // beq via ALU_SUB
   assign ex_o.write_reg      = rd_addr_i;
   assign ex_o.store_data     = rs2_val;
   assign ex_o.alu_result     = result;
   assign ex_o.branch_address = pc_i + imm_i;

endmodule

/* hw/pipe_exmem.sv */
`timescale 1ns/1ps

module pipe_exmem
(
   input  logic      clock,
   input  logic      reset,
   exmem_if.consumer ex_i,
   exmem_if.producer mem_o
);

   // registered every cycle, no stalls so no enable
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         mem_o.mem_read       <= 1'b0;
         mem_o.mem_write      <= 1'b0;
         mem_o.reg_write      <= 1'b0;
         mem_o.write_reg      <= '0;
         mem_o.store_data     <= '0;
         mem_o.alu_result     <= '0;
         mem_o.alu_zero       <= 1'b0;
         mem_o.branch_address <= '0;
         mem_o.branch_en      <= 1'b0;
      end
      else
      begin
         mem_o.mem_read       <= ex_i.mem_read;
         mem_o.mem_write      <= ex_i.mem_write;
         mem_o.reg_write      <= ex_i.reg_write;
         mem_o.write_reg      <= ex_i.write_reg;
         mem_o.store_data     <= ex_i.store_data;
         mem_o.alu_result     <= ex_i.alu_result;
         mem_o.alu_zero       <= ex_i.alu_zero;
         mem_o.branch_address <= ex_i.branch_address;
         mem_o.branch_en      <= ex_i.branch_en;
      end
   end

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/1ps

`include "cpu_backend_params.svh"

module memory_stage
(
   input  logic                           clock,
   input  logic                           reset,
   exmem_if.consumer                      mem_i,
   output logic                           wb_valid_o,
   output logic [`CPU_REG_ADDR_WIDTH-1:0] wb_addr_o,
   output logic [`CPU_DATA_WIDTH-1:0]     wb_data_o
);

   localparam int IDX_W = $clog2(`CPU_DMEM_DEPTH);

   logic [`CPU_DATA_WIDTH-1:0] dmem [`CPU_DMEM_DEPTH];
   logic [IDX_W-1:0]           word_idx;
   logic [`CPU_DATA_WIDTH-1:0] load_data;
   logic [`CPU_DATA_WIDTH-1:0] result;

   assign word_idx  = mem_i.alu_result[IDX_W+2:3];  // byte address / 8, wraps
   assign load_data = dmem[word_idx];                // async read
   assign result    = mem_i.mem_read ? load_data : mem_i.alu_result;

   always_ff @(posedge clock)
   begin
      if (mem_i.mem_write)
      begin
         dmem[word_idx] <= mem_i.store_data;
      end
   end

   // mem/wb register
   always_ff @(posedge clock)
   begin
      if (reset)
         wb_valid_o <= 1'b0;
      else
         wb_valid_o <= mem_i.reg_write;
   end

   always_ff @(posedge clock)
   begin
      wb_addr_o <= mem_i.write_reg;
      wb_data_o <= result;
   end

endmodule

/* hw/cpu_backend.sv */
`timescale 1ns/1ps

`include "cpu_backend_params.svh"

module cpu_backend
(
   input  logic                           clock,
   input  logic                           reset,
   input  logic                           issue_valid_i,
   input  cpu_backend_pkg::alu_op_e       alu_op_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rs1_addr_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rs2_addr_i,
   input  logic [`CPU_REG_ADDR_WIDTH-1:0] rd_addr_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     imm_i,
   input  logic                           use_imm_i,
   input  logic                           mem_read_i,
   input  logic                           mem_write_i,
   input  logic                           reg_write_i,
   input  logic                           branch_i,
   input  logic [`CPU_DATA_WIDTH-1:0]     pc_i,
   output logic                           wb_valid_o,
   output logic [`CPU_REG_ADDR_WIDTH-1:0] wb_addr_o,
   output logic [`CPU_DATA_WIDTH-1:0]     wb_data_o,
   output logic                           branch_taken_o,
   output logic [`CPU_DATA_WIDTH-1:0]     branch_target_o
);

   logic [`CPU_DATA_WIDTH-1:0] rs1_data;
   logic [`CPU_DATA_WIDTH-1:0] rs2_data;

   exmem_if ex_bus ();
   exmem_if mem_bus ();

   register_file u_register_file (
      .clock      (clock),
      .reset      (reset),
      .rs1_addr_i (rs1_addr_i),
      .rs2_addr_i (rs2_addr_i),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wr_en_i    (wb_valid_o),
      .wr_addr_i  (wb_addr_o),
      .wr_data_i  (wb_data_o)
   );

   execute_stage u_execute_stage (
      .issue_valid_i (issue_valid_i),
      .alu_op_i      (alu_op_i),
      .rs1_addr_i    (rs1_addr_i),
      .rs2_addr_i    (rs2_addr_i),
      .rd_addr_i     (rd_addr_i),
      .imm_i         (imm_i),
      .use_imm_i     (use_imm_i),
      .mem_read_i    (mem_read_i),
      .mem_write_i   (mem_write_i),
      .reg_write_i   (reg_write_i),
      .branch_i      (branch_i),
      .pc_i          (pc_i),
      .rs1_data_i    (rs1_data),
      .rs2_data_i    (rs2_data),
      .fwd_mem_i     (mem_bus.consumer),  // ex/mem forwarding path
      .wb_valid_i    (wb_valid_o),
      .wb_addr_i     (wb_addr_o),
      .wb_data_i     (wb_data_o),
      .ex_o          (ex_bus.producer)
   );

   pipe_exmem u_pipe_exmem (
      .clock (clock),
      .reset (reset),
      .ex_i  (ex_bus.consumer),
      .mem_o (mem_bus.producer)
   );

   memory_stage u_memory_stage (
      .clock      (clock),
      .reset      (reset),
      .mem_i      (mem_bus.consumer),
      .wb_valid_o (wb_valid_o),
      .wb_addr_o  (wb_addr_o),
      .wb_data_o  (wb_data_o)
   );

   assign branch_taken_o  = mem_bus.branch_en;       // resolved one cycle after issue
   assign branch_target_o = mem_bus.branch_address;

endmodule

/* verification/cpu_backend_checker.sv */
`timescale 1ns/1ps

module cpu_backend_checker
(
   input logic clock,
   input logic reset,
   input logic issue_valid_i,
   input logic reg_write_i,
   input logic branch_i,
   input logic wb_valid_o,
   input logic branch_taken_o,
   input logic bus_mem_read_i,
   input logic bus_mem_write_i
);

   logic assert_failed = 1'b0;

   property outputs_low_after_reset;
      @(posedge clock) reset |=> (!wb_valid_o && !branch_taken_o);
   endproperty

   property wb_follows_issue;
      @(posedge clock) disable iff (reset)
         wb_valid_o |-> $past(issue_valid_i && reg_write_i, 2);
   endproperty

   property branch_follows_issue;
      @(posedge clock) disable iff (reset)
         branch_taken_o |-> $past(issue_valid_i && branch_i, 1);
   endproperty

   property mem_access_exclusive;
      @(posedge clock) disable iff (reset)
         !(bus_mem_read_i && bus_mem_write_i);
   endproperty

   a_reset_low: assert property (outputs_low_after_reset)
      else
      begin
         $error("control outputs not cleared by reset");
         assert_failed = 1'b1;
      end
   a_wb_src: assert property (wb_follows_issue)
      else
      begin
         $error("writeback without a register-writing issue two cycles earlier");
         assert_failed = 1'b1;
      end
   a_br_src: assert property (branch_follows_issue)
      else
      begin
         $error("branch taken without a branch issue one cycle earlier");
         assert_failed = 1'b1;
      end
   a_mem_excl: assert property (mem_access_exclusive)
      else
      begin
         $error("load and store both set in the memory stage");
         assert_failed = 1'b1;
      end

endmodule

/* verification/cpu_backend_tb.sv */
`timescale 1ns/1ps

`include "cpu_backend_params.svh"

module cpu_backend_tb;

   typedef struct packed {
      logic                           valid;
      cpu_backend_pkg::alu_op_e       op;
      logic [`CPU_REG_ADDR_WIDTH-1:0] rs1;
      logic [`CPU_REG_ADDR_WIDTH-1:0] rs2;
      logic [`CPU_REG_ADDR_WIDTH-1:0] rd;
      logic [`CPU_DATA_WIDTH-1:0]     imm;
      logic                           use_imm;
      logic                           mrd;
      logic                           mwr;
      logic                           rwr;
      logic                           br;
      logic                           exp_taken;
      logic [`CPU_DATA_WIDTH-1:0]     pc;
      logic [`CPU_DATA_WIDTH-1:0]     exp_data;  // wb data, or branch target
   } row_t;

   typedef struct packed {
      logic [31:0]                    cycle;
      cpu_backend_pkg::alu_op_e       op;
      logic [`CPU_REG_ADDR_WIDTH-1:0] addr;
      logic [`CPU_DATA_WIDTH-1:0]     data;
   } wb_exp_t;

   typedef struct packed {
      logic [31:0]                cycle;
      logic                       taken;
      logic [`CPU_DATA_WIDTH-1:0] target;
   } br_exp_t;

   logic clock = 1'b0;
   logic reset = 1'b1;
   logic issue_valid_i = 1'b0;
   cpu_backend_pkg::alu_op_e alu_op_i = cpu_backend_pkg::ALU_ADD;
   logic [`CPU_REG_ADDR_WIDTH-1:0] rs1_addr_i = '0;
   logic [`CPU_REG_ADDR_WIDTH-1:0] rs2_addr_i = '0;
   logic [`CPU_REG_ADDR_WIDTH-1:0] rd_addr_i = '0;
   logic [`CPU_DATA_WIDTH-1:0] imm_i = '0;
   logic use_imm_i = 1'b0;
   logic mem_read_i = 1'b0;
   logic mem_write_i = 1'b0;
   logic reg_write_i = 1'b0;
   logic branch_i = 1'b0;
   logic [`CPU_DATA_WIDTH-1:0] pc_i = '0;
   logic wb_valid_o;
   logic [`CPU_REG_ADDR_WIDTH-1:0] wb_addr_o;
   logic [`CPU_DATA_WIDTH-1:0] wb_data_o;
   logic branch_taken_o;
   logic [`CPU_DATA_WIDTH-1:0] branch_target_o;

   logic [31:0] cyc = 0;  // rising edges seen so far
   logic checking = 1'b0;
   int seed = 87;
   row_t table_rows[$];
   wb_exp_t wq[$];
   br_exp_t bq[$];
   logic [`CPU_DATA_WIDTH-1:0] shadow [1 << `CPU_REG_ADDR_WIDTH];

   cpu_backend uut (.*);

   bind cpu_backend cpu_backend_checker u_checker (
      .clock           (clock),
      .reset           (reset),
      .issue_valid_i   (issue_valid_i),
      .reg_write_i     (reg_write_i),
      .branch_i        (branch_i),
      .wb_valid_o      (wb_valid_o),
      .branch_taken_o  (branch_taken_o),
      .bus_mem_read_i  (mem_bus.mem_read),
      .bus_mem_write_i (mem_bus.mem_write)
   );

   always #50 clock = ~clock;

   always @(posedge clock) cyc <= cyc + 1;

   task automatic stop_with_fail(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_wb(input logic valid, input logic [`CPU_REG_ADDR_WIDTH-1:0] addr,
                           input logic [`CPU_DATA_WIDTH-1:0] data, input wb_exp_t exp);
      if (valid !== 1'b1 || addr !== exp.addr || data !== exp.data)
      begin
         $display("MISMATCH at %0t: %s wb v=%b r%0d=%h, expected r%0d=%h", $time,
                  exp.op.name(), valid, addr, data, exp.addr, exp.data);
         stop_with_fail("writeback check failed");
      end
   endtask

   task automatic check_branch(input logic taken, input logic [`CPU_DATA_WIDTH-1:0] target,
                               input logic exp_taken, input logic [`CPU_DATA_WIDTH-1:0] exp_tgt);
      if (taken !== exp_taken || (exp_taken && target !== exp_tgt))
      begin
         $display("MISMATCH at %0t: branch taken=%b target=%h, expected taken=%b target=%h",
                  $time, taken, target, exp_taken, exp_tgt);
         stop_with_fail("branch check failed");
      end
   endtask

   // reference alu following the opcode rules
   function automatic logic [`CPU_DATA_WIDTH-1:0] alu_model(input cpu_backend_pkg::alu_op_e op,
      input logic [`CPU_DATA_WIDTH-1:0] a, input logic [`CPU_DATA_WIDTH-1:0] b);
      case (op)
         cpu_backend_pkg::ALU_ADD: return a + b;
         cpu_backend_pkg::ALU_SUB: return a - b;
         cpu_backend_pkg::ALU_AND: return a & b;
         cpu_backend_pkg::ALU_OR:  return a | b;
         cpu_backend_pkg::ALU_XOR: return a ^ b;
         cpu_backend_pkg::ALU_SLL: return a << b[5:0];
         cpu_backend_pkg::ALU_SRL: return a >> b[5:0];
         default:                  return ($signed(a) < $signed(b)) ? 1 : 0;
      endcase
   endfunction

   task automatic add_row(input logic valid, input cpu_backend_pkg::alu_op_e op,
                          input int rs1, input int rs2, input int rd,
                          input logic [63:0] imm, input logic [5:0] ctl,
                          input logic [63:0] pc, input logic [63:0] exp_data);
      row_t r;
      r = '{valid, op, rs1, rs2, rd, imm, ctl[5], ctl[4], ctl[3], ctl[2], ctl[1], ctl[0],
            pc, exp_data};
      table_rows.push_back(r);
   endtask

   task automatic issue(input row_t r);
      @(posedge clock);
      issue_valid_i <= r.valid;
      alu_op_i <= r.op;
      rs1_addr_i <= r.rs1;
      rs2_addr_i <= r.rs2;
      rd_addr_i <= r.rd;
      imm_i <= r.imm;
      use_imm_i <= r.use_imm;
      mem_read_i <= r.mrd;
      mem_write_i <= r.mwr;
      reg_write_i <= r.rwr;
      branch_i <= r.br;
      pc_i <= r.pc;
      // cyc still holds the previous edge count here
      if (r.valid && r.rwr)
         wq.push_back('{cyc + 3, r.op, r.rd, r.exp_data});
      if (r.valid && r.br)
         bq.push_back('{cyc + 2, r.exp_taken, r.exp_data});
   endtask

   always @(negedge clock)
   begin
      br_exp_t be;
      if (uut.u_checker.assert_failed)
         stop_with_fail("an assertion in the checker failed");
      if (checking)
      begin
         if (wq.size() > 0 && wq[0].cycle == cyc)
            check_wb(wb_valid_o, wb_addr_o, wb_data_o, wq.pop_front());
         else if (wb_valid_o !== 1'b0)
            stop_with_fail("writeback seen when none was expected");
         if (bq.size() > 0 && bq[0].cycle == cyc)
         begin
            be = bq.pop_front();
            check_branch(branch_taken_o, branch_target_o, be.taken, be.target);
         end
         else
            check_branch(branch_taken_o, branch_target_o, 1'b0, '0);
      end
   end

   initial
   begin
      row_t r;
      int wait_cnt;
      foreach (shadow[i])
      begin
         shadow[i] = '0;  // registers clear on reset
      end
      // ctl bits: use_imm mem_read mem_write reg_write branch exp_taken
      add_row(1, cpu_backend_pkg::ALU_ADD, 0, 0, 0, 64'd40, 6'b101000, 0, 0);  // zero word 5
      add_row(1, cpu_backend_pkg::ALU_ADD, 0, 0, 1, 64'd5, 6'b100100, 0, 64'd5);
      add_row(0, cpu_backend_pkg::ALU_ADD, 0, 0, 0, 0, 6'b000000, 0, 0);
      add_row(1, cpu_backend_pkg::ALU_ADD, 0, 0, 2, 64'd12, 6'b100100, 0, 64'd12);
      add_row(0, cpu_backend_pkg::ALU_ADD, 0, 0, 0, 0, 6'b000000, 0, 0);
      add_row(1, cpu_backend_pkg::ALU_ADD, 0, 0, 3, -64'sd8, 6'b100100, 0, -64'sd8);
      add_row(0, cpu_backend_pkg::ALU_ADD, 0, 0, 0, 0, 6'b000000, 0, 0);
      add_row(1, cpu_backend_pkg::ALU_ADD, 1, 2, 4, 0, 6'b000100, 0, 64'd17);
      add_row(1, cpu_backend_pkg::ALU_SUB, 1, 2, 5, 0, 6'b000100, 0, -64'sd7);
      add_row(1, cpu_backend_pkg::ALU_AND, 1, 2, 6, 0, 6'b000100, 0, 64'd4);
      add_row(1, cpu_backend_pkg::ALU_OR, 1, 2, 7, 0, 6'b000100, 0, 64'd13);
      add_row(1, cpu_backend_pkg::ALU_XOR, 1, 2, 8, 0, 6'b000100, 0, 64'd9);
      add_row(1, cpu_backend_pkg::ALU_SLL, 2, 1, 9, 0, 6'b000100, 0, 64'h180);
      add_row(1, cpu_backend_pkg::ALU_SRL, 3, 1, 10, 0, 6'b000100, 0, 64'h07FF_FFFF_FFFF_FFFF);
      add_row(1, cpu_backend_pkg::ALU_SLT, 3, 1, 11, 0, 6'b000100, 0, 64'd1);
      add_row(1, cpu_backend_pkg::ALU_ADD, 4, 2, 12, 0, 6'b000100, 0, 64'd29);
      add_row(1, cpu_backend_pkg::ALU_SUB, 12, 1, 13, 0, 6'b000100, 0, 64'd24);
      add_row(1, cpu_backend_pkg::ALU_XOR, 12, 13, 14, 0, 6'b000100, 0, 64'd5);
      add_row(1, cpu_backend_pkg::ALU_ADD, 0, 4, 0, 64'd16, 6'b101000, 0, 0);  // store r4
      add_row(1, cpu_backend_pkg::ALU_ADD, 0, 0, 15, 64'd16, 6'b110100, 0, 64'd17);
      add_row(1, cpu_backend_pkg::ALU_ADD, 0, 0, 15, 64'd40, 6'b110100, 0, 64'd0);
      add_row(0, cpu_backend_pkg::ALU_ADD, 0, 0, 0, 0, 6'b000000, 0, 0);
      add_row(1, cpu_backend_pkg::ALU_SUB, 1, 1, 0, 64'h20, 6'b000011, 64'h100, 64'h120);
      add_row(1, cpu_backend_pkg::ALU_SUB, 1, 2, 0, 64'h20, 6'b000010, 64'h200, 64'h220);

      repeat (5) @(posedge clock);
      checking = 1'b1;
      reset <= 1'b0;

      foreach (table_rows[i])
      begin
         if (table_rows[i].valid && table_rows[i].rwr)
            shadow[table_rows[i].rd] = table_rows[i].exp_data;
         issue(table_rows[i]);
      end

      // random back-to-back alu phase
      for (int n = 0; n < 40; n++)
      begin
         r = '0;
         r.valid = 1'b1;
         r.op = cpu_backend_pkg::alu_op_e'($random(seed) & 7);
         r.rs1 = $random(seed);
         r.rs2 = $random(seed);
         r.rd = $random(seed);
         r.use_imm = $random(seed);
         r.imm = {$random(seed), $random(seed)};
         r.rwr = 1'b1;
         r.exp_data = alu_model(r.op, shadow[r.rs1], r.use_imm ? r.imm : shadow[r.rs2]);
         shadow[r.rd] = r.exp_data;
         issue(r);
      end
      issue('0);

      wait_cnt = 0;
      while ((wq.size() > 0 || bq.size() > 0) && wait_cnt < 10)
      begin
         @(posedge clock);
         wait_cnt++;
      end
      @(posedge clock);
      if (wq.size() == 0 && bq.size() == 0)
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
      else
      begin
         $display("timeout: an expected writeback or branch result never arrived");
         $display("Simulation finished: FAIL");
         $fatal(1, "run stopped");
      end
   end

endmodule

/* cpu_backend.f */
+incdir+include
hw/cpu_backend_pkg.sv
hw/exmem_if.sv
hw/register_file.sv
hw/execute_stage.sv
hw/pipe_exmem.sv
hw/memory_stage.sv
hw/cpu_backend.sv
verification/cpu_backend_checker.sv
verification/cpu_backend_tb.sv
